// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - files:
      - source/control_unit_pkg.sv
      - source/instr_decoder.sv
      - source/control_sequencer.sv
      - source/control_encoder.sv
      - source/control_unit.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/control_unit_assertions.sv
      - verif/tb_control_unit.sv

// ==== filelist.f ====
source/control_unit_pkg.sv
source/instr_decoder.sv
source/control_sequencer.sv
source/control_encoder.sv
source/control_unit.sv
verif/tb_clock_gen.sv
verif/control_unit_assertions.sv
verif/tb_control_unit.sv

// ==== source/control_encoder.sv ====
`timescale 1ns/100ps

module control_encoder (
    input control_unit_pkg::state_e state,
    output control_unit_pkg::ctrl_word_t ctrl
);

    always_comb begin
        ctrl = '0;
        case (state)
            // Load the stack pointer with its initial value
            control_unit_pkg::st_sp_init: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst = control_unit_pkg::REG_DST_SP;
                ctrl.mem_to_reg = control_unit_pkg::MEM_TO_REG_SP_INIT;
            end
            control_unit_pkg::st_fetch0: begin
                ctrl.iord = control_unit_pkg::IORD_PC;
                ctrl.alu_src_a = control_unit_pkg::ALU_SRCA_PC;
                ctrl.alu_src_b = control_unit_pkg::ALU_SRCB_FOUR;
                ctrl.alu_op = control_unit_pkg::alu_add;
            end
            control_unit_pkg::st_fetch1: begin
                ctrl.pc_write = 1'b1;
                ctrl.ir_write = 1'b1;
            end
            // Branch target computed speculatively
            control_unit_pkg::st_decode: begin
                ctrl.a_write = 1'b1;
                ctrl.b_write = 1'b1;
                ctrl.alu_src_a = control_unit_pkg::ALU_SRCA_PC;
                ctrl.alu_src_b = control_unit_pkg::ALU_SRCB_BRANCH_OFFSET;
                ctrl.alu_op = control_unit_pkg::alu_add;
            end
            // ALU operation is filled in from the instruction class at the top
            control_unit_pkg::st_execute: begin
                ctrl.alu_src_a = control_unit_pkg::ALU_SRCA_A;
                ctrl.alu_src_b = control_unit_pkg::ALU_SRCB_B;
                ctrl.alu_reg_write = 1'b1;
            end
            control_unit_pkg::st_writeback: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst = control_unit_pkg::REG_DST_RD;
                ctrl.mem_to_reg = control_unit_pkg::MEM_TO_REG_ALUOUT;
            end
            control_unit_pkg::st_noopcode: begin
                ctrl.except = control_unit_pkg::EXC_NOOPCODE;
                ctrl.iord = control_unit_pkg::IORD_EXC_VECTOR;
                ctrl.alu_op = control_unit_pkg::alu_and;
            end
            control_unit_pkg::st_overflow: begin
                ctrl.except = control_unit_pkg::EXC_OVERFLOW;
                ctrl.iord = control_unit_pkg::IORD_EXC_VECTOR;
                ctrl.alu_op = control_unit_pkg::alu_and;
            end
            // Save EPC and jump to the handler
            control_unit_pkg::st_except: begin
                ctrl.epc_write = 1'b1;
                ctrl.pc_write = 1'b1;
                ctrl.pc_src = control_unit_pkg::PC_SRC_EXC;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== source/control_sequencer.sv ====
`timescale 1ns/100ps

module control_sequencer (
    input logic clk,
    input logic reset,
    input logic ov,
    input control_unit_pkg::instr_class_e instr_class,
    output control_unit_pkg::state_e state
);

    control_unit_pkg::state_e next_state;
    logic [control_unit_pkg::WAIT_CNT_W-1:0] wait_cnt;
    logic fetch_done;
    logic except_done;

    assign fetch_done = (wait_cnt == control_unit_pkg::FETCH_WAIT_LAST);
    assign except_done = (wait_cnt == control_unit_pkg::EXCEPT_WAIT_LAST);

    always_comb begin
        next_state = state;
        case (state)
            control_unit_pkg::st_reset: begin
                next_state = control_unit_pkg::st_sp_init;
            end
            control_unit_pkg::st_sp_init: begin
                next_state = control_unit_pkg::st_fetch0;
            end
            // Hold address until memory returns the word
            control_unit_pkg::st_fetch0: begin
                if (fetch_done) begin
                    next_state = control_unit_pkg::st_fetch1;
                end
            end
            control_unit_pkg::st_fetch1: begin
                next_state = control_unit_pkg::st_decode;
            end
            control_unit_pkg::st_decode: begin
                if (instr_class == control_unit_pkg::cls_illegal) begin
                    next_state = control_unit_pkg::st_noopcode;
                end else begin
                    next_state = control_unit_pkg::st_execute;
                end
            end
            // Overflow aborts before the result is written back
            control_unit_pkg::st_execute: begin
                if (ov) begin
                    next_state = control_unit_pkg::st_overflow;
                end else begin
                    next_state = control_unit_pkg::st_writeback;
                end
            end
            control_unit_pkg::st_writeback: begin
                next_state = control_unit_pkg::st_fetch0;
            end
            control_unit_pkg::st_noopcode,
            control_unit_pkg::st_overflow: begin
                if (except_done) begin
                    next_state = control_unit_pkg::st_except;
                end
            end
            control_unit_pkg::st_except: begin
                next_state = control_unit_pkg::st_fetch0;
            end
            default: begin
                next_state = control_unit_pkg::st_reset;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= control_unit_pkg::st_reset;
            wait_cnt <= '0;
        end else begin
            state <= next_state;
            // Restart the count whenever the state moves on
            if (next_state != state) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
    input logic clk,
    input logic reset,
    input logic ov,
    input logic [control_unit_pkg::OPCODE_W-1:0] opcode,
    input logic [control_unit_pkg::FUNCT_W-1:0] funct,
    output logic pc_write,
    output logic ir_write,
    output logic a_write,
    output logic b_write,
    output logic alu_reg_write,
    output logic epc_write,
    output logic reg_write,
    output logic [1:0] reg_dst,
    output logic [1:0] except,
    output logic [1:0] alu_src_a,
    output logic [2:0] iord,
    output logic [2:0] alu_src_b,
    output control_unit_pkg::alu_op_e alu_op,
    output logic [2:0] pc_src,
    output logic [3:0] mem_to_reg
);

    control_unit_pkg::instr_class_e instr_class;
    control_unit_pkg::state_e state;
    control_unit_pkg::ctrl_word_t ctrl;

    instr_decoder instr_decoder_i (
        .opcode(opcode),
        .funct(funct),
        .instr_class(instr_class)
    );

    control_sequencer control_sequencer_i (
        .clk(clk),
        .reset(reset),
        .ov(ov),
        .instr_class(instr_class),
        .state(state)
    );

    control_encoder control_encoder_i (
        .state(state),
        .ctrl(ctrl)
    );

    assign pc_write = ctrl.pc_write;
    assign ir_write = ctrl.ir_write;
    assign a_write = ctrl.a_write;
    assign b_write = ctrl.b_write;
    assign alu_reg_write = ctrl.alu_reg_write;
    assign epc_write = ctrl.epc_write;
    assign reg_write = ctrl.reg_write;
    assign reg_dst = ctrl.reg_dst;
    assign except = ctrl.except;
    assign alu_src_a = ctrl.alu_src_a;
    assign iord = ctrl.iord;
    assign alu_src_b = ctrl.alu_src_b;
    assign pc_src = ctrl.pc_src;
    assign mem_to_reg = ctrl.mem_to_reg;

    // IR holds opcode and funct stable from decode through execute
    always_comb begin
        alu_op = ctrl.alu_op;
        if (state == control_unit_pkg::st_execute) begin
            case (instr_class)
                control_unit_pkg::cls_add: alu_op = control_unit_pkg::alu_add;
                control_unit_pkg::cls_sub: alu_op = control_unit_pkg::alu_sub;
                control_unit_pkg::cls_and: alu_op = control_unit_pkg::alu_and;
                default: alu_op = control_unit_pkg::alu_nop;
            endcase
        end
    end

endmodule

// ==== source/control_unit_pkg.sv ====
package control_unit_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W = 6;

    // Cycles spent waiting on memory reads
    localparam int FETCH_WAIT_CYCLES = 3;
    localparam int EXCEPT_WAIT_CYCLES = 3;

    localparam int WAIT_CNT_W = 2;
    localparam logic [WAIT_CNT_W-1:0] FETCH_WAIT_LAST = WAIT_CNT_W'(FETCH_WAIT_CYCLES - 1);
    localparam logic [WAIT_CNT_W-1:0] EXCEPT_WAIT_LAST = WAIT_CNT_W'(EXCEPT_WAIT_CYCLES - 1);

    // Memory address select
    localparam logic [2:0] IORD_PC = 3'b000;
    localparam logic [2:0] IORD_ALUOUT = 3'b001;
    localparam logic [2:0] IORD_EXC_VECTOR = 3'b010;

    localparam logic [1:0] ALU_SRCA_PC = 2'b00;
    localparam logic [1:0] ALU_SRCA_A = 2'b01;

    localparam logic [2:0] ALU_SRCB_B = 3'b000;
    localparam logic [2:0] ALU_SRCB_FOUR = 3'b001;
    localparam logic [2:0] ALU_SRCB_BRANCH_OFFSET = 3'b011;

    localparam logic [2:0] PC_SRC_ALU = 3'b000;
    localparam logic [2:0] PC_SRC_EXC = 3'b011;

    localparam logic [1:0] REG_DST_RD = 2'b01;
    localparam logic [1:0] REG_DST_SP = 2'b10;

    localparam logic [3:0] MEM_TO_REG_ALUOUT = 4'b0000;
    localparam logic [3:0] MEM_TO_REG_SP_INIT = 4'b0100;

    // Exception cause, selects the handler vector
    localparam logic [1:0] EXC_NOOPCODE = 2'b00;
    localparam logic [1:0] EXC_OVERFLOW = 2'b01;

    typedef enum logic [6:0] {
        st_reset = 7'd0,
        st_sp_init = 7'd1,
        st_fetch0 = 7'd2,
        st_fetch1 = 7'd3,
        st_decode = 7'd4,
        st_execute = 7'd5,
        st_writeback = 7'd6,
        st_noopcode = 7'd7,
        st_overflow = 7'd8,
        st_except = 7'd9
    } state_e;

    typedef enum logic [1:0] {
        cls_add = 2'd0,
        cls_sub = 2'd1,
        cls_and = 2'd2,
        cls_illegal = 2'd3
    } instr_class_e;

    typedef enum logic [OPCODE_W-1:0] {
        opc_rtype = 6'h00
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        funct_add = 6'h20,
        funct_sub = 6'h22,
        funct_and = 6'h24
    } funct_e;

    typedef enum logic [2:0] {
        alu_nop = 3'b000,
        alu_add = 3'b001,
        alu_and = 3'b010,
        alu_sub = 3'b011
    } alu_op_e;

    typedef struct packed {
        logic pc_write;
        logic ir_write;
        logic a_write;
        logic b_write;
        logic alu_reg_write;
        logic epc_write;
        logic reg_write;
        logic [1:0] reg_dst;
        logic [1:0] except;
        logic [1:0] alu_src_a;
        logic [2:0] iord;
        logic [2:0] alu_src_b;
        alu_op_e alu_op;
        logic [2:0] pc_src;
        logic [3:0] mem_to_reg;
    } ctrl_word_t;

endpackage

// ==== source/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
    input logic [control_unit_pkg::OPCODE_W-1:0] opcode,
    input logic [control_unit_pkg::FUNCT_W-1:0] funct,
    output control_unit_pkg::instr_class_e instr_class
);

    logic [control_unit_pkg::FUNCT_W-1:0] rtype_funct;
    logic is_rtype;

    assign is_rtype = (opcode == control_unit_pkg::opc_rtype);

    // Non R-type opcodes never match a funct code
    assign rtype_funct = is_rtype ? funct : '1;

    always_comb begin
        case (rtype_funct)
            control_unit_pkg::funct_add: begin
                instr_class = control_unit_pkg::cls_add;
            end
            control_unit_pkg::funct_sub: begin
                instr_class = control_unit_pkg::cls_sub;
            end
            control_unit_pkg::funct_and: begin
                instr_class = control_unit_pkg::cls_and;
            end
            // Everything else, implemented in the ISA or not
            default: begin
                instr_class = control_unit_pkg::cls_illegal;
            end
        endcase
    end

endmodule

// ==== verif/control_unit_assertions.sv ====
`timescale 1ns/100ps

module control_unit_assertions (
    input logic clk,
    input logic reset,
    input logic pc_write,
    input logic ir_write,
    input logic a_write,
    input logic b_write,
    input logic alu_reg_write,
    input logic epc_write,
    input logic reg_write,
    input logic [1:0] reg_dst,
    input logic [1:0] except,
    input logic [1:0] alu_src_a,
    input logic [2:0] iord,
    input logic [2:0] alu_src_b,
    input logic [2:0] alu_op,
    input logic [2:0] pc_src,
    input logic [3:0] mem_to_reg
);

    int fail_count = 0;
    logic reset_seen = 1'b0;

    // State is unknown until the first clock edge under reset
    always_ff @(posedge clk) begin
        if (reset) begin
            reset_seen <= 1'b1;
        end
    end

    ir_needs_pc: assert property (@(posedge clk) disable iff (reset) ir_write |-> pc_write)
        else begin
            $error("ir_write asserted without pc_write");
            fail_count++;
        end

    epc_needs_jump: assert property (@(posedge clk) disable iff (reset)
        epc_write |-> pc_write && pc_src == control_unit_pkg::PC_SRC_EXC)
        else begin
            $error("epc_write asserted without a jump to the exception handler");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk) reset && reset_seen |->
        {pc_write, ir_write, a_write, b_write, alu_reg_write, epc_write, reg_write, reg_dst,
        except, alu_src_a, iord, alu_src_b, alu_op, pc_src, mem_to_reg} == '0)
        else begin
            $error("control output active while reset is high");
            fail_count++;
        end

endmodule

bind control_unit control_unit_assertions control_unit_assertions_i (.*);

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release on a falling edge like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== verif/tb_control_unit.sv ====
`timescale 1ns/100ps

module tb_control_unit;

    localparam int RESET_CYCLES = 8;
    localparam int ILLEGAL_RUNS = 8;
    localparam int MIXED_RUNS = 30;
    // Overflow is the longest instruction at 10 cycles
    localparam int TIMEOUT_CYCLES =
        RESET_CYCLES + 2 + 3 * 7 + 10 + ILLEGAL_RUNS * 9 + MIXED_RUNS * 10 + 40;

    logic clk;
    logic reset;
    logic ov;
    logic [control_unit_pkg::OPCODE_W-1:0] opcode;
    logic [control_unit_pkg::FUNCT_W-1:0] funct;
    logic pc_write;
    logic ir_write;
    logic a_write;
    logic b_write;
    logic alu_reg_write;
    logic epc_write;
    logic reg_write;
    logic [1:0] reg_dst;
    logic [1:0] except;
    logic [1:0] alu_src_a;
    logic [2:0] iord;
    logic [2:0] alu_src_b;
    control_unit_pkg::alu_op_e alu_op;
    logic [2:0] pc_src;
    logic [3:0] mem_to_reg;
    control_unit_pkg::ctrl_word_t actual;

    tb_clock_gen clock_gen_i (
        .clk(clk),
        .reset(reset)
    );

    control_unit control_unit_i (.*);

    assign actual = {pc_write, ir_write, a_write, b_write, alu_reg_write, epc_write, reg_write,
        reg_dst, except, alu_src_a, iord, alu_src_b, alu_op, pc_src, mem_to_reg};

    // Expected outputs per state, from the state table
    function automatic control_unit_pkg::ctrl_word_t model_word(
        input control_unit_pkg::state_e st,
        input control_unit_pkg::instr_class_e cls
    );
        control_unit_pkg::ctrl_word_t w;
        w = '0;
        case (st)
            control_unit_pkg::st_sp_init: begin
                w.reg_write = 1'b1;
                w.reg_dst = control_unit_pkg::REG_DST_SP;
                w.mem_to_reg = control_unit_pkg::MEM_TO_REG_SP_INIT;
            end
            control_unit_pkg::st_fetch0: begin
                w.iord = control_unit_pkg::IORD_PC;
                w.alu_src_a = control_unit_pkg::ALU_SRCA_PC;
                w.alu_src_b = control_unit_pkg::ALU_SRCB_FOUR;
                w.alu_op = control_unit_pkg::alu_add;
            end
            control_unit_pkg::st_fetch1: begin
                w.pc_write = 1'b1;
                w.ir_write = 1'b1;
            end
            control_unit_pkg::st_decode: begin
                w.a_write = 1'b1;
                w.b_write = 1'b1;
                w.alu_src_a = control_unit_pkg::ALU_SRCA_PC;
                w.alu_src_b = control_unit_pkg::ALU_SRCB_BRANCH_OFFSET;
                w.alu_op = control_unit_pkg::alu_add;
            end
            control_unit_pkg::st_execute: begin
                w.alu_src_a = control_unit_pkg::ALU_SRCA_A;
                w.alu_src_b = control_unit_pkg::ALU_SRCB_B;
                w.alu_reg_write = 1'b1;
                w.alu_op = (cls == control_unit_pkg::cls_sub) ? control_unit_pkg::alu_sub :
                    (cls == control_unit_pkg::cls_and) ? control_unit_pkg::alu_and :
                    control_unit_pkg::alu_add;
            end
            control_unit_pkg::st_writeback: begin
                w.reg_write = 1'b1;
                w.reg_dst = control_unit_pkg::REG_DST_RD;
                w.mem_to_reg = control_unit_pkg::MEM_TO_REG_ALUOUT;
            end
            control_unit_pkg::st_noopcode,
            control_unit_pkg::st_overflow: begin
                w.except = (st == control_unit_pkg::st_overflow) ?
                    control_unit_pkg::EXC_OVERFLOW : control_unit_pkg::EXC_NOOPCODE;
                w.iord = control_unit_pkg::IORD_EXC_VECTOR;
                w.alu_op = control_unit_pkg::alu_and;
            end
            control_unit_pkg::st_except: begin
                w.epc_write = 1'b1;
                w.pc_write = 1'b1;
                w.pc_src = control_unit_pkg::PC_SRC_EXC;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic control_unit_pkg::instr_class_e class_of(input logic [5:0] opc,
        input logic [5:0] fn);
        if (opc != control_unit_pkg::opc_rtype) begin
            return control_unit_pkg::cls_illegal;
        end
        case (fn)
            control_unit_pkg::funct_add: return control_unit_pkg::cls_add;
            control_unit_pkg::funct_sub: return control_unit_pkg::cls_sub;
            control_unit_pkg::funct_and: return control_unit_pkg::cls_and;
            default: return control_unit_pkg::cls_illegal;
        endcase
    endfunction

    task automatic check_word(input string test, input control_unit_pkg::ctrl_word_t expected);
        assert (actual === expected) else begin
            $display("mismatch %s: expected %h, actual %h", test, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Starts and ends on the falling edge of a first fetch cycle
    task automatic run_instr(input string test, input logic [5:0] opc, input logic [5:0] fn,
        input logic ov_bit);
        control_unit_pkg::instr_class_e cls;
        control_unit_pkg::state_e seq[$];
        cls = class_of(opc, fn);
        opcode = opc;
        funct = fn;
        repeat (control_unit_pkg::FETCH_WAIT_CYCLES) seq.push_back(control_unit_pkg::st_fetch0);
        seq.push_back(control_unit_pkg::st_fetch1);
        seq.push_back(control_unit_pkg::st_decode);
        if (cls == control_unit_pkg::cls_illegal) begin
            repeat (control_unit_pkg::EXCEPT_WAIT_CYCLES)
                seq.push_back(control_unit_pkg::st_noopcode);
            seq.push_back(control_unit_pkg::st_except);
        end else if (ov_bit) begin
            seq.push_back(control_unit_pkg::st_execute);
            repeat (control_unit_pkg::EXCEPT_WAIT_CYCLES)
                seq.push_back(control_unit_pkg::st_overflow);
            seq.push_back(control_unit_pkg::st_except);
        end else begin
            seq.push_back(control_unit_pkg::st_execute);
            seq.push_back(control_unit_pkg::st_writeback);
        end
        foreach (seq[i]) begin
            // Opposite ov level outside execute must be ignored
            ov = (seq[i] == control_unit_pkg::st_execute) ? ov_bit : ~ov_bit;
            check_word(test, model_word(seq[i], cls));
            @(negedge clk);
        end
    endtask

    task automatic random_illegal(output logic [5:0] opc, output logic [5:0] fn);
        do begin
            // Half the draws stay R-type to reach the unused funct codes
            opc = ($urandom_range(1) == 0) ? control_unit_pkg::opc_rtype : 6'($urandom);
            fn = 6'($urandom);
        end while (class_of(opc, fn) != control_unit_pkg::cls_illegal);
    endtask

    task automatic reset_and_init();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_word("reset", '0);
        end
        wait (!reset);
        @(negedge clk);
        check_word("sp_init",
            model_word(control_unit_pkg::st_sp_init, control_unit_pkg::cls_add));
        @(negedge clk);
        check_word("first_fetch",
            model_word(control_unit_pkg::st_fetch0, control_unit_pkg::cls_add));
    endtask

    task automatic three_alu_instrs();
        run_instr("add", control_unit_pkg::opc_rtype, control_unit_pkg::funct_add, 1'b0);
        run_instr("sub", control_unit_pkg::opc_rtype, control_unit_pkg::funct_sub, 1'b0);
        run_instr("and", control_unit_pkg::opc_rtype, control_unit_pkg::funct_and, 1'b0);
    endtask

    task automatic add_with_overflow();
        run_instr("add_overflow", control_unit_pkg::opc_rtype, control_unit_pkg::funct_add, 1'b1);
    endtask

    task automatic illegal_sequences();
        logic [5:0] opc;
        logic [5:0] fn;
        repeat (ILLEGAL_RUNS) begin
            random_illegal(opc, fn);
            run_instr("illegal", opc, fn, 1'b0);
        end
    endtask

    task automatic mixed_random_run();
        logic [5:0] opc;
        logic [5:0] fn;
        int pick;
        repeat (MIXED_RUNS) begin
            pick = $urandom_range(3);
            opc = control_unit_pkg::opc_rtype;
            case (pick)
                0: fn = control_unit_pkg::funct_add;
                1: fn = control_unit_pkg::funct_sub;
                2: fn = control_unit_pkg::funct_and;
                default: random_illegal(opc, fn);
            endcase
            run_instr("mixed", opc, fn, 1'($urandom_range(1)));
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * 10);
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (control_unit_i.control_unit_assertions_i.fail_count != 0);
        $display("a concurrent assertion on the control outputs failed");
        $display("Simulation failed");
        $fatal(1, "concurrent assertion failed");
    end

    initial begin
        void'($urandom(49));
        ov = 1'b0;
        opcode = '0;
        funct = '0;
        reset_and_init();
        three_alu_instrs();
        add_with_overflow();
        illegal_sequences();
        mixed_random_run();
        $display("Simulation passed");
        $finish;
    end

endmodule
